// File: hdl/vga_pkg.sv
`default_nettype none

package vga_pkg;

	//////////////////////////////////////////////////
	// 640x480 raster at a 25 MHz pixel clock
	//////////////////////////////////////////////////

	// Horizontal timing in pixels
	localparam int H_VISIBLE    = 640;
	localparam int H_SYNC_START = 656;
	localparam int H_SYNC_END   = 752;
	localparam int H_TOTAL      = 800;

	// Vertical timing in lines
	localparam int V_VISIBLE    = 480;
	localparam int V_SYNC_START = 490;
	localparam int V_SYNC_END   = 492;
	localparam int V_TOTAL      = 525;

	// Raster coordinate wide enough for both totals
	typedef logic [9:0] coord_t;

	//////////////////////////////////////////////////
	// Pixel bundle from timing to renderer
	//////////////////////////////////////////////////

	typedef struct packed {
		coord_t hcount;
		coord_t vcount;
		logic   visible;
		logic   hsync_n;
		logic   vsync_n;
	} raster_t;

endpackage

`default_nettype wire

// File: hdl/game_pkg.sv
`default_nettype none

package game_pkg;

	//////////////////////////////////////////////////
	// Grid layout
	//////////////////////////////////////////////////

	localparam int CARD_COUNT = 16;
	localparam int PAIR_COUNT = 8;
	localparam int GRID_DIM   = 4;
	localparam int CARD_SIZE  = 83;
	localparam int CARD_PITCH = 100;
	localparam int GRID_X0    = 130;
	localparam int GRID_Y0    = 70;

	// Card face drawing
	localparam int BORDER_W = 2;
	localparam int INSET    = 21;

	localparam logic [2:0] RGB_NONE       = 3'b000;
	localparam logic [2:0] RGB_BACK       = 3'b001;
	localparam logic [2:0] RGB_MATCH_EDGE = 3'b010;
	localparam logic [2:0] RGB_EDGE       = 3'b111;

	// Frame starts a mismatched pair stays face up
	localparam int HOLD_FRAMES = 2;

	typedef logic [3:0] card_pos_t;
	typedef logic [2:0] symbol_t;

	typedef enum logic [1:0] {
		CARD_DOWN,
		CARD_UP,
		CARD_MATCHED
	} card_state_t;

	typedef card_state_t [CARD_COUNT-1:0] board_state_t;

	typedef enum logic [1:0] {
		OUT_FLIPPED,
		OUT_MATCH,
		OUT_MISMATCH,
		OUT_REJECTED
	} outcome_t;

	typedef struct packed {
		card_pos_t pos;
	} select_t;

	typedef struct packed {
		card_pos_t  pos;
		outcome_t   outcome;
		logic [7:0] moves;
	} result_t;

	// Fixed deal so cards p and p+8 share a symbol
	function automatic symbol_t card_symbol(card_pos_t pos);
		return pos[2:0];
	endfunction

endpackage

`default_nettype wire

// File: hdl/vga_timing.sv
`timescale 1ns/100ps
`default_nettype none

module vga_timing (
	input  logic             clk,
	input  logic             reset,
	output vga_pkg::raster_t raster,
	output logic             frame_start
);
	import vga_pkg::*;

	coord_t h_count;
	coord_t v_count;

	// Free-running raster counters
	always_ff @(posedge clk) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == coord_t'(H_TOTAL - 1)) begin
			h_count <= '0;
			if (v_count == coord_t'(V_TOTAL - 1))
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	// Visible flag and active-low syncs from the counts
	always_comb begin
		raster.hcount  = h_count;
		raster.vcount  = v_count;
		raster.visible = (h_count < coord_t'(H_VISIBLE)) &&
		                 (v_count < coord_t'(V_VISIBLE));
		raster.hsync_n = !((h_count >= coord_t'(H_SYNC_START)) &&
		                   (h_count < coord_t'(H_SYNC_END)));
		raster.vsync_n = !((v_count >= coord_t'(V_SYNC_START)) &&
		                   (v_count < coord_t'(V_SYNC_END)));
	end

	// Start of vertical blanking
	assign frame_start = (h_count == '0) && (v_count == coord_t'(V_VISIBLE));

	a_hcount_range: assert property (@(posedge clk) disable iff (reset)
		h_count < coord_t'(H_TOTAL));

endmodule

`default_nettype wire

// File: hdl/card_board.sv
`timescale 1ns/100ps
`default_nettype none

module card_board (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   sel_valid,
	output logic                   sel_ready,
	input  game_pkg::select_t      sel,
	input  logic                   frame_start,
	output logic                   result_valid,
	output game_pkg::result_t      result,
	output game_pkg::board_state_t board,
	output logic                   done
);
	import game_pkg::*;

	typedef enum logic [1:0] {
		BOARD_IDLE,
		BOARD_ONE_UP,
		BOARD_HOLD
	} ctrl_t;

	typedef logic [$clog2(HOLD_FRAMES + 1)-1:0] hold_cnt_t;
	typedef logic [$clog2(PAIR_COUNT + 1)-1:0]  pair_cnt_t;

	ctrl_t                 ctrl;
	card_pos_t             first_pos;
	card_pos_t             second_pos;
	hold_cnt_t             hold_count;
	pair_cnt_t             pairs;
	logic [7:0]            moves;
	logic [7:0]            moves_next;
	logic                  accept;
	logic                  is_down;
	logic                  is_pair;
	outcome_t              outcome_next;
	logic [CARD_COUNT-1:0] up_mask;

	assign accept     = sel_valid && sel_ready;
	assign is_down    = (board[sel.pos] == CARD_DOWN);
	assign is_pair    = (card_symbol(sel.pos) == card_symbol(first_pos));
	assign moves_next = moves + 8'd1;

	// Judgement of the offered card
	always_comb begin
		if (!is_down)
			outcome_next = OUT_REJECTED;
		else if (ctrl != BOARD_ONE_UP)
			outcome_next = OUT_FLIPPED;
		else if (is_pair)
			outcome_next = OUT_MATCH;
		else
			outcome_next = OUT_MISMATCH;
	end

	//////////////////////////////////////////////////
	// Board controller
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl         <= BOARD_IDLE;
			first_pos    <= '0;
			second_pos   <= '0;
			hold_count   <= '0;
			pairs        <= '0;
			moves        <= '0;
			sel_ready    <= 1'b1;
			result_valid <= 1'b0;
			done         <= 1'b0;
			for (int i = 0; i < CARD_COUNT; i++)
				board[i] <= CARD_DOWN;
		end else begin
			result_valid <= accept;
			if (accept) begin
				case (outcome_next)
					OUT_FLIPPED: begin
						board[sel.pos] <= CARD_UP;
						first_pos      <= sel.pos;
						ctrl           <= BOARD_ONE_UP;
					end
					OUT_MATCH: begin
						board[sel.pos]   <= CARD_MATCHED;
						board[first_pos] <= CARD_MATCHED;
						moves            <= moves_next;
						pairs            <= pairs + 1'b1;
						done             <= (pairs == pair_cnt_t'(PAIR_COUNT - 1));
						ctrl             <= BOARD_IDLE;
					end
					OUT_MISMATCH: begin
						board[sel.pos] <= CARD_UP;
						second_pos     <= sel.pos;
						moves          <= moves_next;
						hold_count     <= '0;
						sel_ready      <= 1'b0;
						ctrl           <= BOARD_HOLD;
					end
					default: begin
						// Rejected card leaves the board untouched
					end
				endcase
			end else if ((ctrl == BOARD_HOLD) && frame_start) begin
				if (hold_count == hold_cnt_t'(HOLD_FRAMES - 1)) begin
					board[first_pos]  <= CARD_DOWN;
					board[second_pos] <= CARD_DOWN;
					sel_ready         <= 1'b1;
					ctrl              <= BOARD_IDLE;
				end else begin
					hold_count <= hold_count + 1'b1;
				end
			end
		end
	end

	// Result payload with moves counting judged pairs only
	always_ff @(posedge clk) begin
		if (accept) begin
			result.pos     <= sel.pos;
			result.outcome <= outcome_next;
			if ((outcome_next == OUT_MATCH) || (outcome_next == OUT_MISMATCH))
				result.moves <= moves_next;
			else
				result.moves <= moves;
		end
	end

	always_comb begin
		for (int i = 0; i < CARD_COUNT; i++)
			up_mask[i] = (board[i] == CARD_UP);
	end

	a_two_up_max: assert property (@(posedge clk) disable iff (reset)
		$countones(up_mask) <= 2);

	a_hold_stall: assert property (@(posedge clk) disable iff (reset)
		(ctrl == BOARD_HOLD) |-> !sel_ready);

endmodule

`default_nettype wire

// File: hdl/card_renderer.sv
`timescale 1ns/100ps
`default_nettype none

module card_renderer (
	input  logic                   clk,
	input  logic                   reset,
	input  vga_pkg::raster_t       raster,
	input  game_pkg::board_state_t board,
	output logic [2:0]             rgb,
	output logic                   hsync_n,
	output logic                   vsync_n
);
	import vga_pkg::*;
	import game_pkg::*;

	typedef logic [6:0] offset_t;

	// Hit flag and index of the card span holding v
	function automatic logic [2:0] locate(coord_t v, int origin);
		logic [2:0] found;
		found = 3'b000;
		for (int i = 0; i < GRID_DIM; i++) begin
			if ((int'(v) >= origin + i * CARD_PITCH) &&
			    (int'(v) < origin + i * CARD_PITCH + CARD_SIZE))
				found = {1'b1, 2'(i)};
		end
		return found;
	endfunction

	//////////////////////////////////////////////////
	// Stage 1 grid lookup
	//////////////////////////////////////////////////

	logic [2:0] col_loc;
	logic [2:0] row_loc;
	coord_t     x_off;
	coord_t     y_off;
	card_pos_t  pos;

	always_comb begin
		col_loc = locate(raster.hcount, GRID_X0);
		row_loc = locate(raster.vcount, GRID_Y0);
		x_off   = raster.hcount - coord_t'(GRID_X0 + CARD_PITCH * int'(col_loc[1:0]));
		y_off   = raster.vcount - coord_t'(GRID_Y0 + CARD_PITCH * int'(row_loc[1:0]));
		pos     = {row_loc[1:0], col_loc[1:0]};
	end

	logic        s1_visible;
	logic        s1_on_card;
	logic        s1_hsync_n;
	logic        s1_vsync_n;
	offset_t     s1_lx;
	offset_t     s1_ly;
	card_state_t s1_state;
	symbol_t     s1_symbol;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_visible <= 1'b0;
			s1_on_card <= 1'b0;
			s1_hsync_n <= 1'b1;
			s1_vsync_n <= 1'b1;
		end else begin
			s1_visible <= raster.visible;
			s1_on_card <= col_loc[2] && row_loc[2];
			s1_hsync_n <= raster.hsync_n;
			s1_vsync_n <= raster.vsync_n;
		end
	end

	always_ff @(posedge clk) begin
		s1_lx     <= offset_t'(x_off);
		s1_ly     <= offset_t'(y_off);
		s1_state  <= board[pos];
		s1_symbol <= card_symbol(pos);
	end

	//////////////////////////////////////////////////
	// Stage 2 colour rule
	//////////////////////////////////////////////////

	logic       border;
	logic       centre;
	logic [2:0] colour;
	logic       s2_visible;

	always_comb begin
		border = (s1_lx < offset_t'(BORDER_W)) || (s1_ly < offset_t'(BORDER_W)) ||
		         (s1_lx >= offset_t'(CARD_SIZE - BORDER_W)) ||
		         (s1_ly >= offset_t'(CARD_SIZE - BORDER_W));
		centre = (s1_lx >= offset_t'(INSET)) && (s1_lx <= offset_t'(CARD_SIZE - 1 - INSET)) &&
		         (s1_ly >= offset_t'(INSET)) && (s1_ly <= offset_t'(CARD_SIZE - 1 - INSET));
		if (!s1_visible || !s1_on_card)
			colour = RGB_NONE;
		else if (border)
			colour = (s1_state == CARD_MATCHED) ? RGB_MATCH_EDGE : RGB_EDGE;
		else if (s1_state == CARD_DOWN)
			colour = RGB_BACK;
		else if (centre)
			colour = ~s1_symbol;
		else
			colour = s1_symbol;
	end

	// Syncs delayed alongside the colour
	always_ff @(posedge clk) begin
		if (reset) begin
			rgb        <= RGB_NONE;
			hsync_n    <= 1'b1;
			vsync_n    <= 1'b1;
			s2_visible <= 1'b0;
		end else begin
			rgb        <= colour;
			hsync_n    <= s1_hsync_n;
			vsync_n    <= s1_vsync_n;
			s2_visible <= s1_visible;
		end
	end

	a_blank_black: assert property (@(posedge clk) disable iff (reset)
		!s2_visible |-> rgb == RGB_NONE);

endmodule

`default_nettype wire

// File: hdl/memory_game_top.sv
`timescale 1ns/100ps
`default_nettype none

module memory_game_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              sel_valid,
	output logic              sel_ready,
	input  game_pkg::select_t sel,
	output logic              result_valid,
	output game_pkg::result_t result,
	output logic              done,
	output logic [2:0]        rgb,
	output logic              hsync_n,
	output logic              vsync_n
);
	import vga_pkg::*;
	import game_pkg::*;

	raster_t      raster;
	logic         frame_start;
	board_state_t board;

	vga_timing vga_timing_i (
		.clk         (clk),
		.reset       (reset),
		.raster      (raster),
		.frame_start (frame_start)
	);

	card_board card_board_i (
		.clk          (clk),
		.reset        (reset),
		.sel_valid    (sel_valid),
		.sel_ready    (sel_ready),
		.sel          (sel),
		.frame_start  (frame_start),
		.result_valid (result_valid),
		.result       (result),
		.board        (board),
		.done         (done)
	);

	card_renderer card_renderer_i (
		.clk     (clk),
		.reset   (reset),
		.raster  (raster),
		.board   (board),
		.rgb     (rgb),
		.hsync_n (hsync_n),
		.vsync_n (vsync_n)
	);

endmodule

`default_nettype wire

// File: sim/tb_memory_game.sv
`timescale 1ns/100ps
`default_nettype none

module tb_memory_game;
	import vga_pkg::*;
	import game_pkg::*;

	localparam string GOLDEN_FILE   = "sim/memory_game_golden.txt";
	localparam int    CLK_PERIOD    = 40;
	localparam int    DRIVE_DELAY   = 2;
	localparam int    RESET_CYCLES  = 16;
	localparam int    FRAME_CYCLES  = H_TOTAL * V_TOTAL;
	localparam int    MARGIN_FRAMES = 3;

	typedef struct packed {
		logic [7:0] kind;
		int         a;
		int         b;
		int         c;
	} cmd_t;

	logic       clk;
	logic       reset;
	logic       sel_valid;
	logic       sel_ready;
	select_t    sel;
	logic       result_valid;
	result_t    result;
	logic       done;
	logic [2:0] rgb;
	logic       hsync_n;
	logic       vsync_n;

	cmd_t   cmds[$];
	int     errors;
	int     checks;
	int     pairs_seen;
	longint watch_ns;

	// Raster position of the pixel now on the outputs
	coord_t     px;
	coord_t     py;
	logic       synced;
	logic [2:0] pix_rgb;
	logic       last_hs;
	logic       last_vs;
	int         frames;
	logic       hold_watch;
	int         hold_frame;

	memory_game_top memory_game_top_i (
		.clk          (clk),
		.reset        (reset),
		.sel_valid    (sel_valid),
		.sel_ready    (sel_ready),
		.sel          (sel),
		.result_valid (result_valid),
		.result       (result),
		.done         (done),
		.rgb          (rgb),
		.hsync_n      (hsync_n),
		.vsync_n      (vsync_n)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Output raster tracking from the sync edges
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (reset) begin
			synced = 1'b0;
			px     = '0;
			py     = '0;
		end else if (last_vs && !vsync_n) begin
			synced = 1'b1;
			frames++;
			px     = '0;
			py     = coord_t'(V_SYNC_START);
		end else if (last_hs && !hsync_n) begin
			px = coord_t'(H_SYNC_START);
		end else if (px == coord_t'(H_TOTAL - 1)) begin
			px = '0;
			py = (py == coord_t'(V_TOTAL - 1)) ? '0 : py + 10'd1;
		end else begin
			px = px + 10'd1;
		end
		// Sync pulses end where the raster constants put them
		if (synced && !last_hs && hsync_n)
			check_value("hsync_n rise x", px, H_SYNC_END);
		if (synced && !last_vs && vsync_n)
			check_value("vsync_n rise y", py, V_SYNC_END);
		// Hold lasts until the second frame start after the mismatch
		if (hold_watch && (frames > hold_frame) && (py == coord_t'(V_VISIBLE - 1)))
			hold_watch = 1'b0;
		if (hold_watch)
			check_value("sel_ready", sel_ready, 0);
		pix_rgb = rgb;
		last_hs = hsync_n;
		last_vs = vsync_n;
	end

	//////////////////////////////////////////////////
	// Command handling
	//////////////////////////////////////////////////

	task automatic read_golden();
		int   fd;
		int   ch;
		int   n;
		int   a;
		int   b;
		int   c;
		cmd_t cmd;
		fd = $fopen(GOLDEN_FILE, "r");
		assert (fd != 0) else begin
			errors++;
			$display("The golden file %s could not be opened", GOLDEN_FILE);
		end
		if (fd == 0)
			return;
		ch = $fgetc(fd);
		while (ch != -1) begin
			if (ch == "#") begin
				while ((ch != -1) && (ch != "\n"))
					ch = $fgetc(fd);
			end else if ((ch == "S") || (ch == "P") || (ch == "W")) begin
				a = 0;
				b = 0;
				c = 0;
				if (ch == "W")
					n = $fscanf(fd, " %d", a) + 2;
				else
					n = $fscanf(fd, " %d %d %d", a, b, c);
				assert (n == 3) else begin
					errors++;
					$display("A golden line of kind %c has missing fields", ch);
				end
				cmd = '{kind: 8'(ch), a: a, b: b, c: c};
				cmds.push_back(cmd);
			end
			ch = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	task automatic select_card(input int pos, input int exp_outcome, input int exp_moves);
		int waited;
		waited = 0;
		@(posedge clk);
		#DRIVE_DELAY;
		sel_valid = 1'b1;
		sel.pos   = card_pos_t'(pos);
		@(negedge clk);
		while (!sel_ready && (waited < 3 * FRAME_CYCLES)) begin
			@(negedge clk);
			waited++;
		end
		assert (sel_ready) else begin
			errors++;
			$display("Selection of card %0d was never accepted", pos);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		sel_valid = 1'b0;
		@(negedge clk);
		if (exp_outcome == int'(OUT_MATCH))
			pairs_seen++;
		check_value("result_valid", result_valid, 1);
		check_value("result.pos", result.pos, pos);
		check_value("result.outcome", result.outcome, exp_outcome);
		check_value("result.moves", result.moves, exp_moves);
		check_value("done", done, (pairs_seen == PAIR_COUNT) ? 1 : 0);
		if (exp_outcome == int'(OUT_MISMATCH)) begin
			check_value("sel_ready", sel_ready, 0);
			hold_frame = frames;
			hold_watch = 1'b1;
		end
		// Result is a single-cycle pulse
		@(negedge clk);
		check_value("result_valid", result_valid, 0);
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frames + n;
		while (frames < target)
			@(posedge clk);
	endtask

	task automatic probe_pixel(input int x, input int y, input int exp_rgb);
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!(synced && (px == coord_t'(x)) && (py == coord_t'(y))) &&
		           (waited < 2 * FRAME_CYCLES));
		assert (waited < 2 * FRAME_CYCLES) else begin
			errors++;
			$display("The raster never reached pixel (%0d,%0d)", x, y);
		end
		check_value($sformatf("rgb at (%0d,%0d)", x, y), pix_rgb, exp_rgb);
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		longint test_frames;
		reset      = 1'b1;
		sel_valid  = 1'b0;
		sel        = '0;
		errors     = 0;
		checks     = 0;
		pairs_seen = 0;
		frames     = 0;
		hold_watch = 1'b0;
		hold_frame = 0;
		last_hs    = 1'b1;
		last_vs    = 1'b1;
		watch_ns   = 0;
		read_golden();
		assert (cmds.size() > 0) else begin
			errors++;
			$display("The golden file holds no commands");
		end
		// One frame per selection plus every wait
		test_frames = MARGIN_FRAMES;
		foreach (cmds[i]) begin
			if (cmds[i].kind == "W")
				test_frames += cmds[i].a;
			else if (cmds[i].kind == "S")
				test_frames += 1;
		end
		watch_ns = test_frames * FRAME_CYCLES * CLK_PERIOD;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		foreach (cmds[i]) begin
			case (cmds[i].kind)
				"S": select_card(cmds[i].a, cmds[i].b, cmds[i].c);
				"W": wait_frames(cmds[i].a);
				default: probe_pixel(cmds[i].a, cmds[i].b, cmds[i].c);
			endcase
		end
		@(negedge clk);
		check_value("done", done, 1);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		wait (watch_ns != 0);
		#(watch_ns);
		$display("Watchdog expired after %0d ns with the command list unfinished", watch_ns);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/memory_game_golden.txt
# S pos outcome moves  select card pos, outcome 0 flipped 1 match 2 mismatch 3 rejected
# W n  wait n falling vsync edges       P x y rgb  probe pixel (x,y), rgb as a number
P 130 70 7
P 171 111 1
P 220 111 0
P 471 411 1
S 5 0 0
W 1
P 240 180 5
P 271 211 2
S 6 2 1
W 2
P 271 211 1
P 371 211 1
S 3 0 1
S 11 1 2
W 1
P 430 70 2
P 430 270 2
S 3 3 2
S 0 0 2
S 0 3 2
S 8 1 3
S 1 0 3
S 9 1 4
S 2 0 4
S 10 1 5
S 4 0 5
S 12 1 6
S 5 0 6
S 13 1 7
S 6 0 7
S 14 1 8
S 7 0 8
S 15 1 9
W 1
P 430 370 2
P 440 380 7
P 471 411 0

// File: run_sim.sh
#!/bin/sh
# Build and run the memory game testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_memory_game -o tb_memory_game
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_memory_game > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0

// File: src.f
hdl/vga_pkg.sv
hdl/game_pkg.sv
hdl/vga_timing.sv
hdl/card_board.sv
hdl/card_renderer.sv
hdl/memory_game_top.sv
sim/tb_memory_game.sv
